//--- act_top.f
verilog/nn_pkg.sv
verilog/act_lut_rom.sv
verilog/lut_arbiter.sv
verilog/activation_unit.sv
verilog/act_top.sv
sim/lut_arbiter_assert.sv
sim/tb_act_top.sv

//--- Bender.yml
package:
  name: act_top

sources:
  # design, package first
  - verilog/nn_pkg.sv
  - verilog/act_lut_rom.sv
  - verilog/lut_arbiter.sv
  - verilog/activation_unit.sv
  - verilog/act_top.sv
  # testbench and bound arbiter checks
  - target: simulation
    files:
      - sim/lut_arbiter_assert.sv
      - sim/tb_act_top.sv

//--- sim/tb_act_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_act_top
    import nn_pkg::*;
();

    localparam int SEED        = 95868;
    localparam int CLK_PERIOD  = 8;
    localparam int ROUNDS      = 200;
    localparam int ROUND_MAX   = 40;
    localparam int FAIR_CYC    = 60;
    // worst case from last change to stable high
    localparam int SETTLE_MAX  = 28;
    // edges after a change before every write carries the held inputs
    localparam int HOLD_MIN    = 5;
    // all rounds, both fairness phases, reset and slack
    localparam int CYCLE_LIMIT = ROUNDS * ROUND_MAX + 2 * (FAIR_CYC + ROUND_MAX) + 1800;

    logic         clk;
    logic         rst;
    act_in_vec_t  inputs_a;
    act_in_vec_t  inputs_b;
    act_out_vec_t outputs_a;
    act_out_vec_t outputs_b;
    logic         stable_a;
    logic         stable_b;

    int           cycle_cnt = 0;
    // monitor state per group with index 0 for group a
    act_in_vec_t  seen_in [2];
    int           hold [2];
    logic         settled [2];
    logic         low_due [2];

    act_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .inputs_a  (inputs_a),
        .inputs_b  (inputs_b),
        .outputs_a (outputs_a),
        .outputs_b (outputs_b),
        .stable_a  (stable_a),
        .stable_b  (stable_b)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_value(input string sig, input int exp, input int act);
        assert (act == exp) else begin
            $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, sig, exp, act);
            stop_on_error();
        end
    endtask

    // signed address plus 256 saturated to 9 bits
    function automatic act_out_t expected_act(input act_in_t a);
        int s;
        s = a[LUT_ADDR_SIZE-1] ? int'(a) - 2**LUT_ADDR_SIZE : int'(a);
        s = s + 256;
        if (s < 0) begin
            return act_out_t'(0);
        end
        if (s > 511) begin
            return act_out_t'(511);
        end
        return act_out_t'(s);
    endfunction

    function automatic act_in_t rand_act_in();
        act_in_t v;
        if ($urandom % 4 == 0) begin
            // near either end of the signed range so the result saturates
            if ($urandom % 2 == 1) begin
                v = act_in_t'(10'h1c0 + $urandom % 64);
            end else begin
                v = act_in_t'(10'h200 + $urandom % 64);
            end
        end else begin
            v = act_in_t'($urandom);
        end
        // all ones equals the buffer's reset value
        if (v == '1) begin
            v = v - 1'b1;
        end
        return v;
    endfunction

    function automatic act_in_vec_t rand_vec();
        act_in_vec_t v;
        for (int i = 0; i < NEURON_NUM; i++) begin
            v[i] = rand_act_in();
        end
        return v;
    endfunction

    // n slot writes at random positions with repeats allowed
    function automatic act_in_vec_t with_new_slots(input act_in_vec_t vec, input int n);
        act_in_vec_t v;
        v = vec;
        for (int k = 0; k < n; k++) begin
            v[$urandom % NEURON_NUM] = rand_act_in();
        end
        return v;
    endfunction

    task automatic check_outputs(input string name, input act_in_vec_t in,
                                 input act_out_vec_t out);
        for (int i = 0; i < NEURON_NUM; i++) begin
            expect_value($sformatf("outputs_%s[%0d]", name, i), expected_act(in[i]), out[i]);
        end
    endtask

    // every slot still at its reset value
    task automatic check_zero(input string name, input act_out_vec_t out);
        for (int i = 0; i < NEURON_NUM; i++) begin
            expect_value($sformatf("outputs_%s[%0d]", name, i), 0, out[i]);
        end
    endtask

    // per group tracking of held inputs, stable and outputs
    task automatic watch_group(input int g, input string name, input act_in_vec_t in,
                               input act_out_vec_t out, input logic st);
        // change from a settled state already sampled by one edge
        if (low_due[g]) begin
            expect_value({"stable_", name}, 0, st);
        end
        low_due[g] = 1'b0;
        if (in != seen_in[g]) begin
            low_due[g] = settled[g];
            hold[g]    = 0;
        end else if (hold[g] < CYCLE_LIMIT) begin
            hold[g]++;
        end
        seen_in[g] = in;
        if (hold[g] >= SETTLE_MAX) begin
            expect_value({"stable_", name}, 1, st);
        end
        settled[g] = st && (hold[g] >= HOLD_MIN);
        if (settled[g]) begin
            check_outputs(name, in, out);
        end
    endtask

    // sampled at the falling edge away from drive and capture
    always @(negedge clk) begin
        if (rst) begin
            seen_in[0] = inputs_a;
            seen_in[1] = inputs_b;
            for (int g = 0; g < 2; g++) begin
                hold[g]    = 0;
                settled[g] = 1'b0;
                low_due[g] = 1'b0;
            end
        end else begin
            watch_group(0, "a", inputs_a, outputs_a, stable_a);
            watch_group(1, "b", inputs_b, outputs_b, stable_b);
            assert (u_dut.u_arbiter.u_arb_assert.fail_cnt == 0) else begin
                $display("an arbiter assertion failed, see the error above");
                stop_on_error();
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_on_error();
        end
    end

    // one group churns every cycle while the other is held
    task automatic fairness_phase(input bit churn_a);
        @(posedge clk);
        #1;
        inputs_a = rand_vec();
        inputs_b = rand_vec();
        repeat (FAIR_CYC - 1) begin
            @(posedge clk);
            #1;
            if (churn_a) begin
                inputs_a = rand_vec();
            end else begin
                inputs_b = rand_vec();
            end
        end
        // churned group gets to settle as well
        repeat (ROUND_MAX) @(posedge clk);
    endtask

    initial begin
        int len;
        int mode;
        void'($urandom(SEED));
        rst      = 1'b1;
        inputs_a = rand_vec();
        inputs_b = rand_vec();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // nothing written before the first table result
        repeat (2) begin
            @(negedge clk);
            expect_value("stable_a", 0, stable_a);
            expect_value("stable_b", 0, stable_b);
            check_zero("a", outputs_a);
            check_zero("b", outputs_b);
        end
        for (int r = 0; r < ROUNDS; r++) begin
            // 0 changes a, 1 changes b, 2 changes both
            mode = $urandom % 3;
            @(posedge clk);
            #1;
            if (mode != 1) begin
                inputs_a = with_new_slots(inputs_a, 1 + $urandom % NEURON_NUM);
            end
            if (mode != 0) begin
                inputs_b = with_new_slots(inputs_b, 1 + $urandom % NEURON_NUM);
            end
            // short holds cut sweeps short while long ones reach stable
            if ($urandom % 4 == 0) begin
                len = 1 + $urandom % 8;
            end else begin
                len = SETTLE_MAX + 2 + $urandom % (ROUND_MAX - SETTLE_MAX - 1);
            end
            repeat (len - 1) @(posedge clk);
        end
        fairness_phase(1'b1);
        fairness_phase(1'b0);
        @(negedge clk);
        if (u_dut.u_arbiter.u_arb_assert.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("an arbiter assertion failed during the run");
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- sim/lut_arbiter_assert.sv
`default_nettype none
`timescale 1ns/100ps

module lut_arbiter_assert
    import nn_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input lut_req_t [UNIT_NUM-1:0] req,
    input logic     [UNIT_NUM-1:0] gnt
);

    // failure count, polled by the testbench
    int fail_cnt = 0;

    // single table port, one winner at most
    a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else begin
            $error("more than one grant in a cycle");
            fail_cnt++;
        end

    for (genvar i = 0; i < UNIT_NUM; i++) begin : g_unit
        // grant only with the request bit up
        a_gnt_to_req: assert property (@(posedge clk) disable iff (rst)
            gnt[i] |-> req[i].req)
            else begin
                $error("grant to unit %0d without a request", i);
                fail_cnt++;
            end

        // round robin, a waiting unit wins next
        a_wait_bound: assert property (@(posedge clk) disable iff (rst)
            (req[i].req && !gnt[i]) |=> gnt[i])
            else begin
                $error("unit %0d requested for 2 cycles without a grant", i);
                fail_cnt++;
            end
    end

endmodule

bind lut_arbiter lut_arbiter_assert u_arb_assert (
    .clk (clk),
    .rst (rst),
    .req (req),
    .gnt (gnt)
);

`default_nettype wire

//--- verilog/act_top.sv
`default_nettype none
`timescale 1ns/100ps

module act_top
    import nn_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  act_in_vec_t  inputs_a,
    input  act_in_vec_t  inputs_b,
    output act_out_vec_t outputs_a,
    output act_out_vec_t outputs_b,
    output logic         stable_a,
    output logic         stable_b
);

    // per-unit request and grant
    lut_req_t [UNIT_NUM-1:0] unit_req;
    logic     [UNIT_NUM-1:0] unit_gnt;

    // shared table port
    logic     lut_rd_en;
    act_in_t  lut_rd_addr;
    // broadcast to both units
    act_out_t lut_rd_data;

    activation_unit u_unit_a (
        .clk     (clk),
        .rst     (rst),
        .inputs  (inputs_a),
        .req     (unit_req[0]),
        .gnt     (unit_gnt[0]),
        .rd_data (lut_rd_data),
        .outputs (outputs_a),
        .stable  (stable_a)
    );

    activation_unit u_unit_b (
        .clk     (clk),
        .rst     (rst),
        .inputs  (inputs_b),
        .req     (unit_req[1]),
        .gnt     (unit_gnt[1]),
        .rd_data (lut_rd_data),
        .outputs (outputs_b),
        .stable  (stable_b)
    );

    // one table access per cycle
    lut_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .req     (unit_req),
        .gnt     (unit_gnt),
        .rd_en   (lut_rd_en),
        .rd_addr (lut_rd_addr)
    );

    act_lut_rom u_lut (
        .clk     (clk),
        .rd_en   (lut_rd_en),
        .rd_addr (lut_rd_addr),
        .rd_data (lut_rd_data)
    );

endmodule

`default_nettype wire

//--- verilog/activation_unit.sv
`default_nettype none
`timescale 1ns/100ps

module activation_unit
    import nn_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  act_in_vec_t  inputs,
    output lut_req_t     req,
    input  logic         gnt,
    input  act_out_t     rd_data,
    output act_out_vec_t outputs,
    output logic         stable
);

    // slot being requested
    logic [SLOT_W-1:0] cnt;
    // slot whose result is in flight
    logic [SLOT_W-1:0] pend_slot;
    // input value that produced the in-flight result
    act_in_t           pend_in;
    // address held while waiting for a grant
    act_in_t           req_addr;
    logic              req_on;
    // table data arrives this cycle
    logic              busy;
    // inputs that the current outputs were computed from
    act_in_vec_t       in_buf;

    logic              take;

    assign take     = req_on & gnt;
    assign req.req  = req_on;
    assign req.addr = req_addr;

    // request sequencing
    // request drops for one cycle after each grant
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            req_on <= 1'b0;
            busy   <= 1'b0;
        end else begin
            busy <= take;
            if (!req_on) begin
                req_on <= 1'b1;
            end else if (gnt) begin
                req_on <= 1'b0;
                // next slot, wrap after the last one
                if (cnt == SLOT_W'(NEURON_NUM - 1)) begin
                    cnt <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // address captured as the request goes up, then held
    always_ff @(posedge clk) begin
        if (!req_on) begin
            req_addr <= inputs[cnt];
        end
        // remember which slot and value the table is answering
        if (take) begin
            pend_slot <= cnt;
            pend_in   <= req_addr;
        end
    end

    // result write back and settle detection
    always_ff @(posedge clk) begin
        if (rst) begin
            outputs <= '0;
            // all ones, as the reference block does
            in_buf  <= '1;
            stable  <= 1'b0;
        end else begin
            if (busy) begin
                outputs[pend_slot] <= rd_data;
                in_buf[pend_slot]  <= pend_in;
            end
            // high only when every slot reflects the live inputs
            stable <= (inputs == in_buf);
        end
    end

endmodule

`default_nettype wire

//--- verilog/lut_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module lut_arbiter
    import nn_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  lut_req_t [UNIT_NUM-1:0]  req,
    output logic     [UNIT_NUM-1:0]  gnt,
    output logic                     rd_en,
    output act_in_t                  rd_addr
);

    typedef logic [$clog2(UNIT_NUM)-1:0] unit_idx_t;

    // unit granted most recently
    unit_idx_t last_q;
    // unit chosen this cycle
    unit_idx_t win;
    logic      any_req;

    // search starts one past the last winner
    always_comb begin : pick_winner
        int idx;
        win     = last_q;
        any_req = 1'b0;
        for (int k = 1; k <= UNIT_NUM; k++) begin
            idx = (int'(last_q) + k) % UNIT_NUM;
            if (!any_req && req[idx].req) begin
                any_req = 1'b1;
                win     = unit_idx_t'(idx);
            end
        end
    end

    // at most one grant, only to a requester
    always_comb begin
        gnt = '0;
        if (any_req) begin
            gnt[win] = 1'b1;
        end
    end

    // table port follows the winner in the grant cycle
    assign rd_en   = any_req;
    assign rd_addr = req[win].addr;

    // unit 0 gets first priority out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= unit_idx_t'(UNIT_NUM - 1);
        end else if (any_req) begin
            last_q <= win;
        end
    end

endmodule

`default_nettype wire

//--- verilog/act_lut_rom.sv
`default_nettype none
`timescale 1ns/100ps

module act_lut_rom
    import nn_pkg::*;
(
    input  logic     clk,
    input  logic     rd_en,
    input  act_in_t  rd_addr,
    output act_out_t rd_data
);

    // one entry per possible pre-activation value
    act_out_t mem [2**LUT_ADDR_SIZE];

    // contents computed at elaboration
    initial begin
        for (int i = 0; i < 2**LUT_ADDR_SIZE; i++) begin
            mem[i] = hard_sigmoid(act_in_t'(i));
        end
    end

    // synchronous read, holds last value when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/nn_pkg.sv
`default_nettype none

package nn_pkg;

    // neuron slots per group
    localparam int NEURON_NUM    = 6;
    // activation units sharing the table
    localparam int UNIT_NUM      = 2;
    // table address and pre-activation width
    localparam int LUT_ADDR_SIZE = 10;
    // table data and activation width
    localparam int LUT_WIDTH     = 9;
    // slot index width
    localparam int SLOT_W        = 3;

    typedef logic [LUT_ADDR_SIZE-1:0] act_in_t;
    typedef logic [LUT_WIDTH-1:0]     act_out_t;

    // slot i lives at bits [i*width +: width]
    typedef act_in_t  [NEURON_NUM-1:0] act_in_vec_t;
    typedef act_out_t [NEURON_NUM-1:0] act_out_vec_t;

    // table request from one unit
    typedef struct packed {
        logic    req;
        act_in_t addr;
    } lut_req_t;

    // hard sigmoid, signed address plus 256, clamped to 0..511
    function automatic act_out_t hard_sigmoid(input act_in_t a);
        int v;
        v = int'($signed(a)) + 256;
        if (v < 0) begin
            v = 0;
        end else if (v > 511) begin
            v = 511;
        end
        return act_out_t'(v);
    endfunction

endpackage

`default_nettype wire
